/* verilog/ir_pkg.sv */
// instruction register stage package
`default_nettype none

package ir_pkg;

  localparam int XLEN         = 32;
  localparam int FIFO_DEPTH   = 4;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  localparam int NUM_WR_PORTS = 3;

  typedef logic [31:0]         instr_t;
  typedef logic [XLEN-1:0]     reg_data_t;
  typedef logic [4:0]          reg_addr_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;
  // lanes moved in one cycle, 0 to 2
  typedef logic [1:0]          lane_cnt_t;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // decoded entry held in stage 1
  typedef struct packed {
    instr_t    instr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      illegal;
  } ir_dec_t;

  // stage-1 fill level, values double as entry counts
  typedef enum logic [1:0] {
    OCC_EMPTY = 2'd0,
    OCC_ONE   = 2'd1,
    OCC_TWO   = 2'd2
  } occ_e;

endpackage

`default_nettype wire

/* verilog/ir_pair_if.sv */
// two-lane instruction pair interface
`default_nettype none

interface ir_pair_if import ir_pkg::*; ();

  // lane 0 is the older one, valid[1] only with valid[0]
  logic [1:0] valid;
  logic [1:0] rdy;
  instr_t     data0;
  instr_t     data1;

  modport src (
    output valid,
    output data0,
    output data1,
    input  rdy
  );

  modport dst (
    input  valid,
    input  data0,
    input  data1,
    output rdy
  );

endinterface

`default_nettype wire

/* verilog/instr_fifo.sv */
// dual-port stage-0 instruction FIFO
`default_nettype none

module instr_fifo import ir_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      flush_i,
  input  wire logic [1:0] wr_valid_i,
  input  wire instr_t    wr_data0_i,
  input  wire instr_t    wr_data1_i,
  output logic [1:0]     wr_rdy_o,
  ir_pair_if.src         rd
);

  instr_t    mem [FIFO_DEPTH];

  fifo_ptr_t rd_ptr_q;
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_nx;
  fifo_ptr_t wr_ptr_nx;
  fifo_cnt_t cnt_q;

  logic      push0;
  logic      push1;
  logic      pop0;
  logic      pop1;
  lane_cnt_t n_wr;
  lane_cnt_t n_rd;

  // ready depends on the registered count only
  assign wr_rdy_o[0] = cnt_q < fifo_cnt_t'(FIFO_DEPTH);
  assign wr_rdy_o[1] = cnt_q < fifo_cnt_t'(FIFO_DEPTH - 1);

  assign rd.valid[0] = cnt_q != '0;
  assign rd.valid[1] = cnt_q > fifo_cnt_t'(1);

  assign rd_ptr_nx = rd_ptr_q + fifo_ptr_t'(1);
  assign wr_ptr_nx = wr_ptr_q + fifo_ptr_t'(1);

  assign rd.data0 = mem[rd_ptr_q];
  assign rd.data1 = mem[rd_ptr_nx];

  // lane 1 only moves together with lane 0
  assign push0 = wr_valid_i[0] & wr_rdy_o[0];
  assign push1 = wr_valid_i[1] & wr_rdy_o[1] & push0;
  assign pop0  = rd.valid[0] & rd.rdy[0];
  assign pop1  = rd.valid[1] & rd.rdy[1] & pop0;

  assign n_wr = {1'b0, push0} + {1'b0, push1};
  assign n_rd = {1'b0, pop0} + {1'b0, pop1};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(n_rd);
      wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(n_wr);
      cnt_q    <= cnt_q + fifo_cnt_t'(n_wr) - fifo_cnt_t'(n_rd);
    end
  end

  // storage, no write-through to the read side
  always_ff @(posedge clk_i) begin
    if (push0) begin
      mem[wr_ptr_q] <= wr_data0_i;
    end
    if (push1) begin
      mem[wr_ptr_nx] <= wr_data1_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/ir_decoder.sv */
// register usage decoder
`default_nettype none

module ir_decoder import ir_pkg::*; (
  input  wire instr_t instr_i,
  output ir_dec_t     dec_o
);

  logic use1;
  logic use2;
  logic ill;

  always_comb begin
    use1 = 1'b0;
    use2 = 1'b0;
    ill  = 1'b0;
    if (instr_i[1:0] != 2'b11) begin
      // 16-bit encodings are not expanded
      ill = 1'b1;
    end else begin
      unique case (instr_i[6:0])
        OPC_OP, OPC_BRANCH, OPC_STORE: begin
          use1 = 1'b1;
          use2 = 1'b1;
        end
        OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: begin
          use1 = 1'b1;
        end
        OPC_LUI, OPC_AUIPC, OPC_JAL: begin
          use1 = 1'b0;
        end
        // fence is not issued from this stage
        default: ill = 1'b1;
      endcase
    end
  end

  assign dec_o.instr    = instr_i;
  // unused sources point at x0 so the read returns zero
  assign dec_o.rs1      = use1 ? instr_i[19:15] : '0;
  assign dec_o.rs2      = use2 ? instr_i[24:20] : '0;
  assign dec_o.rd       = instr_i[11:7];
  assign dec_o.uses_rs1 = use1;
  assign dec_o.uses_rs2 = use2;
  assign dec_o.illegal  = ill;

endmodule

`default_nettype wire

/* verilog/ir_ctrl.sv */
// stage-1 occupancy and slot control
`default_nettype none

module ir_ctrl import ir_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       flush_i,
  input  wire logic       flush_s0_i,
  input  wire logic       hold_i,
  ir_pair_if.dst          fifo,
  input  wire logic [1:0] ds_rdy_i,
  output logic [1:0]      wr_mem_a_o,
  output logic [1:0]      wr_mem_b_o,
  output logic [1:0]      valid_o,
  output logic            a_is0_o
);

  occ_e      occ_q;
  // 0 selects slot a, 1 selects slot b
  logic      old_ptr_q;
  logic      wr_ptr_q;

  lane_cnt_t occ_cnt;
  lane_cnt_t n_pop;
  lane_cnt_t n_push;
  lane_cnt_t free;
  logic      pop0;
  logic      pop1;
  logic      take0;
  logic      take1;
  logic      s1_en;

  assign occ_cnt = lane_cnt_t'(occ_q);

  assign valid_o[0] = occ_q != OCC_EMPTY;
  assign valid_o[1] = occ_q == OCC_TWO;
  assign a_is0_o    = ~old_ptr_q;

  // downstream lane 1 counts only with lane 0
  assign pop0  = valid_o[0] & ds_rdy_i[0];
  assign pop1  = valid_o[1] & ds_rdy_i[0] & ds_rdy_i[1];
  assign n_pop = {1'b0, pop0} + {1'b0, pop1};

  // slots freed by this cycle's pops can be refilled right away
  assign free  = 2'd2 - occ_cnt + n_pop;
  assign s1_en = ~hold_i & ~flush_i & ~flush_s0_i;

  assign fifo.rdy[0] = s1_en & (free != 2'd0);
  assign fifo.rdy[1] = s1_en & (free == 2'd2);

  assign take0  = fifo.valid[0] & fifo.rdy[0];
  assign take1  = fifo.valid[1] & fifo.rdy[1] & take0;
  assign n_push = {1'b0, take0} + {1'b0, take1};

  // lane 0 fills the write slot, lane 1 the other one
  assign wr_mem_a_o[0] = take0 & ~wr_ptr_q;
  assign wr_mem_a_o[1] = take1 &  wr_ptr_q;
  assign wr_mem_b_o[0] = take0 &  wr_ptr_q;
  assign wr_mem_b_o[1] = take1 & ~wr_ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q     <= OCC_EMPTY;
      old_ptr_q <= 1'b0;
      wr_ptr_q  <= 1'b0;
    end else if (flush_i) begin
      occ_q     <= OCC_EMPTY;
      old_ptr_q <= 1'b0;
      wr_ptr_q  <= 1'b0;
    end else begin
      occ_q     <= occ_e'(occ_cnt - n_pop + n_push);
      old_ptr_q <= old_ptr_q ^ n_pop[0];
      wr_ptr_q  <= wr_ptr_q ^ n_push[0];
    end
  end

endmodule

`default_nettype wire

/* verilog/ir_slot.sv */
// stage-1 slot with forwarded operands
`default_nettype none

module ir_slot import ir_pkg::*; (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic [1:0]                     wr_mem_i,
  input  wire ir_dec_t                        dec0_i,
  input  wire ir_dec_t                        dec1_i,
  input  wire reg_data_t                      rdata_p0a_i,
  input  wire reg_data_t                      rdata_p0b_i,
  input  wire reg_data_t                      rdata_p1a_i,
  input  wire reg_data_t                      rdata_p1b_i,
  input  wire logic [NUM_WR_PORTS-1:0]        rf_we_i,
  input  wire reg_addr_t [NUM_WR_PORTS-1:0]   rf_waddr_i,
  input  wire reg_data_t [NUM_WR_PORTS-1:0]   rf_wdata_i,
  output ir_dec_t                             dec_o,
  output reg_data_t                           op1_o,
  output reg_data_t                           op2_o
);

  logic      load;
  ir_dec_t   dec_in;
  ir_dec_t   dec_q;
  reg_addr_t rs1_q;
  reg_addr_t rs2_q;
  reg_addr_t rs1_sel;
  reg_addr_t rs2_sel;
  reg_data_t rdata_a;
  reg_data_t rdata_b;
  reg_data_t op1_d;
  reg_data_t op2_d;
  reg_data_t op1_q;
  reg_data_t op2_q;

  // later ports win, x0 always reads zero
  function automatic reg_data_t fwd_operand(
    input reg_addr_t addr,
    input reg_data_t base
  );
    reg_data_t res;
    res = base;
    for (int i = 0; i < NUM_WR_PORTS; i++) begin
      if (rf_we_i[i] && (rf_waddr_i[i] == addr)) begin
        res = rf_wdata_i[i];
      end
    end
    if (addr == '0) begin
      res = '0;
    end
    return res;
  endfunction

  assign load    = |wr_mem_i;
  assign dec_in  = wr_mem_i[1] ? dec1_i : dec0_i;
  assign rdata_a = wr_mem_i[1] ? rdata_p1a_i : rdata_p0a_i;
  assign rdata_b = wr_mem_i[1] ? rdata_p1b_i : rdata_p0b_i;

  // compare against the incoming sources while loading
  assign rs1_sel = load ? dec_in.rs1 : rs1_q;
  assign rs2_sel = load ? dec_in.rs2 : rs2_q;

  always_comb begin
    op1_d = fwd_operand(rs1_sel, load ? rdata_a : op1_q);
    op2_d = fwd_operand(rs2_sel, load ? rdata_b : op2_q);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_q <= '0;
      rs2_q <= '0;
      op1_q <= '0;
      op2_q <= '0;
    end else begin
      // operands track register writes every cycle
      op1_q <= op1_d;
      op2_q <= op2_d;
      if (load) begin
        rs1_q <= dec_in.rs1;
        rs2_q <= dec_in.rs2;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      dec_q <= dec_in;
    end
  end

  assign dec_o = dec_q;
  assign op1_o = op1_q;
  assign op2_o = op2_q;

endmodule

`default_nettype wire

/* verilog/ir_stage.sv */
// dual-issue instruction register stage
`default_nettype none

module ir_stage import ir_pkg::*; (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,

  // fetch side
  input  wire logic [1:0]                   us_valid_i,
  input  wire instr_t                       us_instr0_i,
  input  wire instr_t                       us_instr1_i,
  output logic [1:0]                        ir_rdy_o,

  // register file reads, p0 for lane 0 and p1 for lane 1
  output reg_addr_t                         rf_raddr_p0a_o,
  output reg_addr_t                         rf_raddr_p0b_o,
  output reg_addr_t                         rf_raddr_p1a_o,
  output reg_addr_t                         rf_raddr_p1b_o,
  input  wire reg_data_t                    rf_rdata_p0a_i,
  input  wire reg_data_t                    rf_rdata_p0b_i,
  input  wire reg_data_t                    rf_rdata_p1a_i,
  input  wire reg_data_t                    rf_rdata_p1b_i,

  // register file write ports
  input  wire logic [NUM_WR_PORTS-1:0]      rf_we_i,
  input  wire reg_addr_t [NUM_WR_PORTS-1:0] rf_waddr_i,
  input  wire reg_data_t [NUM_WR_PORTS-1:0] rf_wdata_i,

  // issue side
  input  wire logic                         ir_flush_i,
  input  wire logic                         ir_flush_s0_i,
  input  wire logic                         ir_hold_i,
  input  wire logic [1:0]                   ds_rdy_i,
  output logic [1:0]                        ir_valid_o,
  output logic                              ira_is0_o,
  output ir_dec_t                           ira_dec_o,
  output ir_dec_t                           irb_dec_o,
  output reg_data_t                         ira_op1_o,
  output reg_data_t                         ira_op2_o,
  output reg_data_t                         irb_op1_o,
  output reg_data_t                         irb_op2_o
);

  ir_pair_if s0_pair ();

  ir_dec_t    dec0;
  ir_dec_t    dec1;
  logic [1:0] wr_mem_a;
  logic [1:0] wr_mem_b;
  logic       s0_flush;

  assign s0_flush = ir_flush_i | ir_flush_s0_i;

  instr_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (s0_flush),
    .wr_valid_i (us_valid_i),
    .wr_data0_i (us_instr0_i),
    .wr_data1_i (us_instr1_i),
    .wr_rdy_o   (ir_rdy_o),
    .rd         (s0_pair.src)
  );

  ir_decoder u_dec0 (
    .instr_i (s0_pair.data0),
    .dec_o   (dec0)
  );

  ir_decoder u_dec1 (
    .instr_i (s0_pair.data1),
    .dec_o   (dec1)
  );

  assign rf_raddr_p0a_o = dec0.rs1;
  assign rf_raddr_p0b_o = dec0.rs2;
  assign rf_raddr_p1a_o = dec1.rs1;
  assign rf_raddr_p1b_o = dec1.rs2;

  ir_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (ir_flush_i),
    .flush_s0_i (ir_flush_s0_i),
    .hold_i     (ir_hold_i),
    .fifo       (s0_pair.dst),
    .ds_rdy_i   (ds_rdy_i),
    .wr_mem_a_o (wr_mem_a),
    .wr_mem_b_o (wr_mem_b),
    .valid_o    (ir_valid_o),
    .a_is0_o    (ira_is0_o)
  );

  ir_slot u_slot_a (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_mem_i    (wr_mem_a),
    .dec0_i      (dec0),
    .dec1_i      (dec1),
    .rdata_p0a_i (rf_rdata_p0a_i),
    .rdata_p0b_i (rf_rdata_p0b_i),
    .rdata_p1a_i (rf_rdata_p1a_i),
    .rdata_p1b_i (rf_rdata_p1b_i),
    .rf_we_i     (rf_we_i),
    .rf_waddr_i  (rf_waddr_i),
    .rf_wdata_i  (rf_wdata_i),
    .dec_o       (ira_dec_o),
    .op1_o       (ira_op1_o),
    .op2_o       (ira_op2_o)
  );

  ir_slot u_slot_b (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_mem_i    (wr_mem_b),
    .dec0_i      (dec0),
    .dec1_i      (dec1),
    .rdata_p0a_i (rf_rdata_p0a_i),
    .rdata_p0b_i (rf_rdata_p0b_i),
    .rdata_p1a_i (rf_rdata_p1a_i),
    .rdata_p1b_i (rf_rdata_p1b_i),
    .rf_we_i     (rf_we_i),
    .rf_waddr_i  (rf_waddr_i),
    .rf_wdata_i  (rf_wdata_i),
    .dec_o       (irb_dec_o),
    .op1_o       (irb_op1_o),
    .op2_o       (irb_op2_o)
  );

endmodule

`default_nettype wire

/* tests/tb_ir_stage.sv */
// instruction register stage testbench
`default_nettype none

module tb_ir_stage import ir_pkg::*; ();

  localparam int STIM_CYCLES = 1000;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;
  localparam logic [6:0] OPC_TAB [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
    OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM};

  logic                         clk_i;
  logic                         rst_ni;
  logic [1:0]                   us_valid_i;
  instr_t                       us_instr0_i;
  instr_t                       us_instr1_i;
  logic [1:0]                   ir_rdy_o;
  reg_addr_t                    rf_raddr_p0a_o;
  reg_addr_t                    rf_raddr_p0b_o;
  reg_addr_t                    rf_raddr_p1a_o;
  reg_addr_t                    rf_raddr_p1b_o;
  reg_data_t                    rf_rdata_p0a_i;
  reg_data_t                    rf_rdata_p0b_i;
  reg_data_t                    rf_rdata_p1a_i;
  reg_data_t                    rf_rdata_p1b_i;
  logic [NUM_WR_PORTS-1:0]      rf_we_i;
  reg_addr_t [NUM_WR_PORTS-1:0] rf_waddr_i;
  reg_data_t [NUM_WR_PORTS-1:0] rf_wdata_i;
  logic                         ir_flush_i;
  logic                         ir_flush_s0_i;
  logic                         ir_hold_i;
  logic [1:0]                   ds_rdy_i;
  logic [1:0]                   ir_valid_o;
  logic                         ira_is0_o;
  ir_dec_t                      ira_dec_o;
  ir_dec_t                      irb_dec_o;
  reg_data_t                    ira_op1_o;
  reg_data_t                    ira_op2_o;
  reg_data_t                    irb_op1_o;
  reg_data_t                    irb_op2_o;

  // scoreboard and register file model
  reg_data_t   rf_model [32];
  instr_t      exp_q [$];
  int          cycle_cnt = 0;
  logic        run_checks;
  logic        hold_seen = 1'b0;
  logic        flush_seen = 1'b0;
  int          prev_valid = 0;
  int          lat_stage = 0;

  ir_stage DUT (.*);

  assign rf_rdata_p0a_i = rf_model[rf_raddr_p0a_o];
  assign rf_rdata_p0b_i = rf_model[rf_raddr_p0b_o];
  assign rf_rdata_p1a_i = rf_model[rf_raddr_p1a_o];
  assign rf_rdata_p1b_i = rf_model[rf_raddr_p1b_o];

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // register usage rule for one word
  function automatic ir_dec_t expected_decode(input instr_t w);
    ir_dec_t d;
    logic    u1;
    logic    u2;
    logic    bad;
    u1  = 1'b0;
    u2  = 1'b0;
    bad = (w[1:0] != 2'b11);
    if (!bad) begin
      case (w[6:0])
        OPC_OP, OPC_BRANCH, OPC_STORE: begin
          u1 = 1'b1;
          u2 = 1'b1;
        end
        OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: u1 = 1'b1;
        OPC_LUI, OPC_AUIPC, OPC_JAL: u2 = 1'b0;
        default: bad = 1'b1;
      endcase
    end
    d.instr    = w;
    d.rs1      = u1 ? w[19:15] : '0;
    d.rs2      = u2 ? w[24:20] : '0;
    d.rd       = w[11:7];
    d.uses_rs1 = u1;
    d.uses_rs2 = u2;
    d.illegal  = bad;
    return d;
  endfunction

  // small register indices so that addresses collide often
  function automatic instr_t random_instr();
    logic [31:0] r;
    logic [6:0]  opc;
    r   = $urandom;
    opc = (r[3:0] < 4'd11) ? OPC_TAB[r[3:0]] : r[30:24];
    if (r[7:4] == 4'd0) begin
      opc[0] = 1'b0;
    end
    return {r[31:25], 3'b000, r[9:8], 3'b000, r[11:10], r[14:12], 3'b000, r[16:15], opc};
  endfunction

  task automatic check_slot(input logic use_a, input instr_t w);
    ir_dec_t   exp_dec;
    ir_dec_t   got_dec;
    reg_data_t exp1;
    reg_data_t exp2;
    reg_data_t got1;
    reg_data_t got2;
    string     nm;
    nm      = use_a ? "ira" : "irb";
    exp_dec = expected_decode(w);
    got_dec = use_a ? ira_dec_o : irb_dec_o;
    got1    = use_a ? ira_op1_o : irb_op1_o;
    got2    = use_a ? ira_op2_o : irb_op2_o;
    exp1    = (exp_dec.rs1 == '0) ? '0 : rf_model[exp_dec.rs1];
    exp2    = (exp_dec.rs2 == '0) ? '0 : rf_model[exp_dec.rs2];
    assert (got_dec == exp_dec) else
      stop_with_error($sformatf("[FAIL] %s_dec_o got %h expected %h", nm, got_dec, exp_dec));
    assert (got1 == exp1) else
      stop_with_error($sformatf("[FAIL] %s_op1_o got %h expected %h", nm, got1, exp1));
    assert (got2 == exp2) else
      stop_with_error($sformatf("[FAIL] %s_op2_o got %h expected %h", nm, got2, exp2));
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = $urandom;
    us_valid_i    <= (r[1:0] == 2'b00) ? 2'b00 : (r[2] ? 2'b11 : 2'b01);
    us_instr0_i   <= random_instr();
    us_instr1_i   <= random_instr();
    ds_rdy_i      <= r[3] ? 2'b11 : r[5:4];
    ir_hold_i     <= (r[8:6] == 3'd0);
    ir_flush_i    <= (r[14:9] == 6'd0);
    ir_flush_s0_i <= (r[20:15] == 6'd0);
    rf_we_i       <= r[23:21];
    for (int i = 0; i < NUM_WR_PORTS; i++) begin
      rf_waddr_i[i] <= reg_addr_t'(r[25 + 2 * i +: 2]);
      rf_wdata_i[i] <= $urandom;
    end
  endtask

  // port 2 is written last and wins
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 32; i++) begin
        rf_model[i] <= i * 32'h0101_0101;
      end
    end else begin
      for (int i = 0; i < NUM_WR_PORTS; i++) begin
        if (rf_we_i[i] && (rf_waddr_i[i] != '0)) begin
          rf_model[rf_waddr_i[i]] <= rf_wdata_i[i];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_with_error("the run did not finish within the cycle limit");
    end
  end

  // sampled at the falling edge ahead of the next transfer edge
  always @(negedge clk_i) begin
    int   n_valid;
    int   n_pop;
    logic push0;
    logic push1;
    logic was_empty;
    if (run_checks) begin
      n_valid = ir_valid_o[1] ? 2 : (ir_valid_o[0] ? 1 : 0);
      n_pop   = 0;
      if (ir_valid_o[0] && ds_rdy_i[0]) begin
        n_pop = (ir_valid_o[1] && ds_rdy_i[1]) ? 2 : 1;
      end
      push0     = us_valid_i[0] && ir_rdy_o[0];
      push1     = push0 && us_valid_i[1] && ir_rdy_o[1];
      was_empty = (exp_q.size() == 0);

      assert (!(ir_valid_o[1] && !ir_valid_o[0])) else
        stop_with_error("ir_valid_o lane 1 is high without lane 0");
      assert (!hold_seen || n_valid <= prev_valid) else
        stop_with_error("ir_valid_o gained an entry while ir_hold_i was high");
      assert (!flush_seen || ir_valid_o == 2'b00) else
        stop_with_error($sformatf("[FAIL] ir_valid_o got %h expected %h", ir_valid_o, 2'b00));
      assert (lat_stage != 2 || ir_valid_o == 2'b11) else
        stop_with_error($sformatf("[FAIL] ir_valid_o got %h expected %h", ir_valid_o, 2'b11));
      assert (exp_q.size() >= n_valid) else
        stop_with_error("a slot is valid with no accepted word left to match it");
      if (n_valid > 0) begin
        check_slot(ira_is0_o, exp_q[0]);
      end
      if (n_valid > 1) begin
        check_slot(!ira_is0_o, exp_q[1]);
      end

      if (ir_flush_i) begin
        exp_q.delete();
      end else begin
        repeat (n_pop) begin
          void'(exp_q.pop_front());
        end
        if (ir_flush_s0_i) begin
          // only the slot entries that stay survive
          while (exp_q.size() > n_valid - n_pop) begin
            void'(exp_q.pop_back());
          end
        end else begin
          if (push0) begin
            exp_q.push_back(us_instr0_i);
          end
          if (push1) begin
            exp_q.push_back(us_instr1_i);
          end
        end
      end
      assert (exp_q.size() <= 6) else
        stop_with_error("more than six accepted words are in flight");

      // pair into empty stages must show one edge after it is taken
      if (lat_stage == 1 && !ir_flush_i && !ir_flush_s0_i && !ir_hold_i) begin
        lat_stage = 2;
      end else if (was_empty && push1 && !ir_flush_i && !ir_flush_s0_i) begin
        lat_stage = 1;
      end else begin
        lat_stage = 0;
      end
      hold_seen  = ir_hold_i;
      flush_seen = ir_flush_i;
      prev_valid = n_valid;
    end
  end

  initial begin
    void'($urandom(19));
    run_checks    <= 1'b0;
    rst_ni        <= 1'b0;
    us_valid_i    <= '0;
    us_instr0_i   <= '0;
    us_instr1_i   <= '0;
    rf_we_i       <= '0;
    rf_waddr_i    <= '0;
    rf_wdata_i    <= '0;
    ir_flush_i    <= 1'b0;
    ir_flush_s0_i <= 1'b0;
    ir_hold_i     <= 1'b0;
    ds_rdy_i      <= '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (ir_valid_o == 2'b00 && ir_rdy_o == 2'b11) else
      stop_with_error($sformatf("[FAIL] ir_valid_o/ir_rdy_o got %h/%h expected %h/%h",
        ir_valid_o, ir_rdy_o, 2'b00, 2'b11));
    run_checks <= 1'b1;
    repeat (STIM_CYCLES) begin
      @(posedge clk_i);
      drive_inputs();
    end
    @(negedge clk_i);
    @(negedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/ir_pkg.sv
verilog/ir_pair_if.sv
verilog/instr_fifo.sv
verilog/ir_decoder.sv
verilog/ir_ctrl.sv
verilog/ir_slot.sv
verilog/ir_stage.sv
tests/tb_ir_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then decide by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ir_stage -f filelist.f \
  && { ./obj_dir/Vtb_ir_stage 2>&1 | tee sim.log || true; } \
  && grep -q "ALL CHECKS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
